// ==== hdl/apb_window_regs.sv ====
`default_nettype none

`include "window_defs.svh"

module apb_window_regs import window_pkg::*; (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire apb_req_t               apb_req,
    output apb_rsp_t                    apb_rsp,
    input  wire logic                   busy,
    input  wire logic                   frame_end,
    input  wire logic                   win_valid,
    output logic                        start,
    output logic                        pix_we,
    output logic [`PIX_ADDR_W-1:0]      pix_addr,
    output pixel_t                      pix_wdata
);

    logic                   access;
    logic                   wr_access;
    logic                   rd_access;
    logic                   pix_sel;
    logic                   pix_in_range;
    logic [`APB_ADDR_W-1:0] pix_offset;
    logic                   frame_done;
    logic [15:0]            win_count;

    ////////////////////
    // Access decode

    assign access    = apb_req.psel & apb_req.penable;  // Access phase only
    assign wr_access = access & apb_req.pwrite;
    assign rd_access = access & ~apb_req.pwrite;

    assign pix_offset   = apb_req.paddr - `PIX_BASE;
    assign pix_sel      = (apb_req.paddr >= `PIX_BASE);
    assign pix_in_range = (pix_offset[`APB_ADDR_W-1:2] < `IMG_WIDTH * `IMG_HEIGHT);

    // One pixel per 32-bit word, low byte lanes carry the data
    assign pix_we    = wr_access & pix_sel & pix_in_range & ~busy;
    assign pix_addr  = pix_offset[`PIX_ADDR_W+1:2];
    assign pix_wdata = apb_req.pwdata[`PIXEL_W-1:0];

    assign start = wr_access & (apb_req.paddr == `REG_CTRL) & apb_req.pwdata[0] & ~busy;

    ////////////////////
    // Status and count

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            frame_done <= 1'b0;
        end else if (frame_end) begin
            frame_done <= 1'b1;  // Set wins over a clearing read
        end else if (rd_access && apb_req.paddr == `REG_STATUS) begin
            frame_done <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            win_count <= '0;
        end else if (start) begin
            win_count <= '0;
        end else if (win_valid) begin
            win_count <= win_count + 16'd1;
        end
    end

    ////////////////////
    // Response

    always_comb begin
        apb_rsp.prdata  = '0;
        apb_rsp.pready  = 1'b1;  // No wait states
        apb_rsp.pslverr = wr_access & pix_sel & busy;  // Frame store is locked while scanning
        if (rd_access) begin
            case (apb_req.paddr)
                `REG_STATUS: apb_rsp.prdata = {30'b0, frame_done, busy};
                `REG_COUNT:  apb_rsp.prdata = {16'b0, win_count};
                default:     apb_rsp.prdata = '0;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hdl/frame_store.sv ====
`default_nettype none

`include "window_defs.svh"

module frame_store import window_pkg::*; (
    input  wire logic                   clk,
    input  wire logic                   we,
    input  wire logic [`PIX_ADDR_W-1:0] wr_addr,
    input  wire pixel_t                 wr_data,
    input  wire logic [`PIX_ADDR_W-1:0] rd_addr,
    output pixel_t                      rd_data
);

    localparam int DEPTH = `IMG_WIDTH * `IMG_HEIGHT;

    pixel_t mem [DEPTH];

    ////////////////////
    // Host write port

    always_ff @(posedge clk) begin
        if (we) begin
            mem[wr_addr] <= wr_data;
        end
    end

    ////////////////////
    // Scan read port

    // One cycle of read latency, matched by the window builder
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

`default_nettype wire

// ==== hdl/line_buffer_window.sv ====
`default_nettype none

`include "window_defs.svh"

module line_buffer_window import window_pkg::*; (
    input  wire logic   clk,
    input  wire logic   rst_n,
    input  wire logic   start,
    input  wire pixel_t pixel_in,
    input  wire logic   shift_en,
    input  wire logic   row_valid,
    output window_t     win,
    output logic        win_valid
);

    logic   shift_q;
    pixel_t line_0 [`IMG_WIDTH];  // Row above the current one
    pixel_t line_1 [`IMG_WIDTH];  // Two rows above
    pixel_t up_1;
    pixel_t up_2;

    assign up_1 = line_0[`IMG_WIDTH-1];
    assign up_2 = line_1[`IMG_WIDTH-1];

    ////////////////////
    // Input stage

    // The scan enable is delayed once to meet the registered memory read
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            shift_q   <= 1'b0;
            win_valid <= 1'b0;
        end else begin
            shift_q   <= shift_en;
            win_valid <= shift_q & row_valid;
        end
    end

    ////////////////////
    // Line buffers

    always_ff @(posedge clk) begin
        if (start) begin
            for (int i = 0; i < `IMG_WIDTH; i++) begin
                line_0[i] <= '0;  // Rows above the image read as zero
                line_1[i] <= '0;
            end
        end else if (shift_q) begin
            line_0[0] <= pixel_in;
            line_1[0] <= up_1;
            for (int i = 1; i < `IMG_WIDTH; i++) begin
                line_0[i] <= line_0[i-1];
                line_1[i] <= line_1[i-1];
            end
        end
    end

    ////////////////////
    // Window array

    // New column enters on the right, oldest column drops off the left
    always_ff @(posedge clk) begin
        if (shift_q) begin
            win.p00 <= win.p01;
            win.p01 <= win.p02;
            win.p02 <= up_2;
            win.p10 <= win.p11;
            win.p11 <= win.p12;
            win.p12 <= up_1;
            win.p20 <= win.p21;
            win.p21 <= win.p22;
            win.p22 <= pixel_in;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/pixel_scan_counter.sv ====
`default_nettype none

`include "window_defs.svh"

module pixel_scan_counter import window_pkg::*; (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire logic                   start,
    input  wire logic                   count_en,
    output logic [`PIX_ADDR_W-1:0]      rd_addr,
    output scan_flags_t                 flags
);

    localparam int COL_W = $clog2(`IMG_WIDTH);
    localparam int ROW_W = $clog2(`IMG_HEIGHT + 1);  // Must reach IMG_HEIGHT

    logic [COL_W-1:0] col;
    logic [ROW_W-1:0] row;

    ////////////////////
    // Raster counters

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            col <= '0;
            row <= '0;
        end else if (start) begin
            col <= '0;
            row <= '0;
        end else if (count_en) begin
            if (col == COL_W'(`IMG_WIDTH - 1)) begin
                col <= '0;
                row <= row + 1'b1;
            end else begin
                col <= col + 1'b1;
            end
        end
    end

    assign rd_addr = `PIX_ADDR_W'(row * `IMG_WIDTH + col);

    ////////////////////
    // Controller flags

    assign flags.row_eq_max       = (row == ROW_W'(`IMG_HEIGHT));  // Past the last row
    assign flags.col_eq_max       = (col == COL_W'(`IMG_WIDTH - 1));
    assign flags.col_ge_threshold = (col >= COL_W'(`COL_THRESHOLD));

endmodule

`default_nettype wire

// ==== hdl/window_controller.sv ====
`default_nettype none

module window_controller import window_pkg::*; (
    input  wire logic        clk,
    input  wire logic        rst_n,
    input  wire logic        start,
    input  wire scan_flags_t flags,
    output logic             count_en,
    output logic             row_valid,
    output logic             frame_end,
    output logic             busy
);

    win_state_e state;
    win_state_e next_state;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    ////////////////////
    // Next state

    always_comb begin
        next_state = state;
        case (state)
            IDLE:       next_state = start ? START : IDLE;
            START:      next_state = START_COL;
            START_COL: begin
                if (flags.row_eq_max) begin
                    next_state = FINISH_ALL;
                end else if (flags.col_ge_threshold) begin
                    next_state = COL_OUT;  // Column 2 address is issued now
                end
            end
            COL_OUT: begin
                if (flags.row_eq_max) begin
                    next_state = FINISH_ALL;
                end else if (flags.col_eq_max) begin
                    next_state = END_COL;
                end
            end
            END_COL:    next_state = flags.row_eq_max ? FINISH_ALL : END_COL_2;
            END_COL_2:  next_state = flags.row_eq_max ? FINISH_ALL : START_COL;
            FINISH_ALL: next_state = DONE;
            DONE:       next_state = IDLE;
            default:    next_state = IDLE;
        endcase
    end

    ////////////////////
    // Outputs

    always_comb begin
        count_en  = 1'b0;
        row_valid = 1'b0;
        frame_end = 1'b0;
        case (state)
            START_COL: count_en = 1'b1;
            COL_OUT: begin
                count_en  = 1'b1;
                row_valid = 1'b1;
            end
            END_COL:    row_valid = 1'b1;  // Covers the pixel of the last column
            FINISH_ALL: frame_end = 1'b1;
            default: begin
                count_en  = 1'b0;
                row_valid = 1'b0;
                frame_end = 1'b0;
            end
        endcase
    end

    assign busy = (state != IDLE);

endmodule

`default_nettype wire

// ==== hdl/window_defs.svh ====
`ifndef WINDOW_DEFS_SVH
`define WINDOW_DEFS_SVH

////////////////////
// Image geometry
`define IMG_WIDTH      8
`define IMG_HEIGHT     6
`define PIXEL_W        8
`define PIX_ADDR_W     $clog2(`IMG_WIDTH * `IMG_HEIGHT)

// First column that completes a 3x3 window
`define COL_THRESHOLD  2

////////////////////
// APB register map
`define APB_ADDR_W     12
`define REG_CTRL       12'h000
`define REG_STATUS     12'h004
`define REG_COUNT      12'h008
`define PIX_BASE       12'h400

`endif

// ==== hdl/window_pkg.sv ====
`default_nettype none

`include "window_defs.svh"

package window_pkg;

    typedef logic [`PIXEL_W-1:0] pixel_t;

    // Row 0 is the oldest row, column 0 the oldest column
    typedef struct packed {
        pixel_t p00;
        pixel_t p01;
        pixel_t p02;
        pixel_t p10;
        pixel_t p11;
        pixel_t p12;
        pixel_t p20;
        pixel_t p21;
        pixel_t p22;
    } window_t;

    typedef struct packed {
        logic                   psel;
        logic                   penable;
        logic                   pwrite;
        logic [`APB_ADDR_W-1:0] paddr;
        logic [31:0]            pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

    typedef enum logic [2:0] {
        IDLE       = 3'b000,
        START      = 3'b001,
        START_COL  = 3'b010,
        COL_OUT    = 3'b011,
        END_COL    = 3'b100,
        END_COL_2  = 3'b101,
        FINISH_ALL = 3'b110,
        DONE       = 3'b111
    } win_state_e;

    typedef struct packed {
        logic row_eq_max;
        logic col_eq_max;
        logic col_ge_threshold;
    } scan_flags_t;

endpackage

`default_nettype wire

// ==== hdl/window_top.sv ====
`default_nettype none

`include "window_defs.svh"

module window_top import window_pkg::*; (
    input  wire logic     clk,
    input  wire logic     rst_n,
    input  wire apb_req_t apb_req,
    output apb_rsp_t      apb_rsp,
    output window_t       win,
    output logic          win_valid,
    output logic          frame_irq
);

    logic                   start;
    logic                   busy;
    logic                   frame_end;
    logic                   pix_we;
    logic [`PIX_ADDR_W-1:0] pix_addr;
    pixel_t                 pix_wdata;
    logic [`PIX_ADDR_W-1:0] rd_addr;
    pixel_t                 rd_pixel;
    scan_flags_t            scan_flags;
    logic                   count_en;
    logic                   row_valid;

    ////////////////////
    // Host side

    apb_window_regs u_apb_regs (
        .clk       (clk),
        .rst_n     (rst_n),
        .apb_req   (apb_req),
        .apb_rsp   (apb_rsp),
        .busy      (busy),
        .frame_end (frame_end),
        .win_valid (win_valid),
        .start     (start),
        .pix_we    (pix_we),
        .pix_addr  (pix_addr),
        .pix_wdata (pix_wdata)
    );

    frame_store u_frame_store (
        .clk     (clk),
        .we      (pix_we),
        .wr_addr (pix_addr),
        .wr_data (pix_wdata),
        .rd_addr (rd_addr),
        .rd_data (rd_pixel)
    );

    ////////////////////
    // Scan side

    pixel_scan_counter u_scan (
        .clk      (clk),
        .rst_n    (rst_n),
        .start    (start),
        .count_en (count_en),
        .rd_addr  (rd_addr),
        .flags    (scan_flags)
    );

    window_controller u_ctrl (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start),
        .flags     (scan_flags),
        .count_en  (count_en),
        .row_valid (row_valid),
        .frame_end (frame_end),
        .busy      (busy)
    );

    line_buffer_window u_window (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start),
        .pixel_in  (rd_pixel),
        .shift_en  (count_en),  // Delayed inside to match the read latency
        .row_valid (row_valid),
        .win       (win),
        .win_valid (win_valid)
    );

    assign frame_irq = frame_end;

endmodule

`default_nettype wire

// ==== testbench/window_chk.sv ====
`default_nettype none

module window_chk import window_pkg::*; (
    input wire logic     clk,
    input wire logic     rst_n,
    input wire apb_req_t apb_req,
    input wire apb_rsp_t apb_rsp,
    input wire logic     busy,
    input wire logic     count_en,
    input wire logic     row_valid,
    input wire logic     win_valid,
    input wire logic     frame_irq
);

    int fail_count = 0;  // Read by the testbench at the end of the run

    ////////////////////
    // Window path

    valid_while_busy: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(win_valid) |-> busy)
        else begin
            $error("win_valid rose while the controller was idle");
            fail_count++;
        end

    irq_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        frame_irq |=> !frame_irq)
        else begin
            $error("frame_irq lasted more than one cycle");
            fail_count++;
        end

    idle_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        !busy |-> (!count_en && !row_valid))
        else begin
            $error("count_en or row_valid high in IDLE");
            fail_count++;
        end

    ////////////////////
    // APB side

    slverr_in_access: assert property (@(posedge clk) disable iff (!rst_n)
        apb_rsp.pslverr |-> (apb_req.psel && apb_req.penable))
        else begin
            $error("pslverr outside an access phase");
            fail_count++;
        end

endmodule

bind window_top window_chk u_chk (
    .clk       (clk),
    .rst_n     (rst_n),
    .apb_req   (apb_req),
    .apb_rsp   (apb_rsp),
    .busy      (busy),
    .count_en  (count_en),
    .row_valid (row_valid),
    .win_valid (win_valid),
    .frame_irq (frame_irq)
);

`default_nettype wire

// ==== testbench/window_tb.sv ====
`default_nettype none

`include "window_defs.svh"

module window_tb import window_pkg::*;;

    localparam int NPIX         = `IMG_WIDTH * `IMG_HEIGHT;
    localparam int WINS         = `IMG_HEIGHT * (`IMG_WIDTH - 2);
    localparam int FRAME_CYCLES = `IMG_HEIGHT * (`IMG_WIDTH + 6);
    localparam int APB_CYCLES   = 4 * 3 * (NPIX + 8);  // Three cycles per transfer
    localparam int WATCHDOG     = (4 * FRAME_CYCLES + APB_CYCLES) * 4;

    logic        clk = 1'b0;
    logic        rst_n;
    apb_req_t    apb_req;
    apb_rsp_t    apb_rsp;
    window_t     win;
    logic        win_valid;
    logic        frame_irq;
    pixel_t      frame_px [NPIX];  // Copy of the frame held in the DUT
    logic [31:0] lcg_state = 32'hb84f;
    int          exp_row = 0;
    int          exp_col = `COL_THRESHOLD;
    int          win_seen = 0;
    int          irq_count = 0;
    window_t     exp_win;

    window_top dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .apb_req   (apb_req),
        .apb_rsp   (apb_rsp),
        .win       (win),
        .win_valid (win_valid),
        .frame_irq (frame_irq)
    );

    always #2 clk = ~clk;

    ////////////////////
    // Helpers

    function automatic logic [31:0] next_random(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic pixel_t expected_pixel(input int r, input int c);
        if (r < 0) return '0;  // Rows above the image
        return frame_px[r * `IMG_WIDTH + c];
    endfunction

    function automatic window_t expected_window(input int r, input int c);
        window_t w;
        w.p00 = expected_pixel(r - 2, c - 2);
        w.p01 = expected_pixel(r - 2, c - 1);
        w.p02 = expected_pixel(r - 2, c);
        w.p10 = expected_pixel(r - 1, c - 2);
        w.p11 = expected_pixel(r - 1, c - 1);
        w.p12 = expected_pixel(r - 1, c);
        w.p20 = expected_pixel(r, c - 2);
        w.p21 = expected_pixel(r, c - 1);
        w.p22 = expected_pixel(r, c);
        return w;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("mismatch %s got 0x%0h expected 0x%0h", name, got, exp);
            $display("Finished with errors");
            $fatal(1, "value check failed");
        end
    endtask

    task automatic write_reg(input logic [`APB_ADDR_W-1:0] addr, input logic [31:0] data,
                             output logic err);
        @(posedge clk);
        #1;
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = 1'b1;
        apb_req.paddr   = addr;
        apb_req.pwdata  = data;
        @(posedge clk);
        #1;
        apb_req.penable = 1'b1;
        @(negedge clk);
        check_value("pready", apb_rsp.pready, 1);
        err = apb_rsp.pslverr;
        @(posedge clk);
        #1;
        apb_req = '0;
    endtask

    task automatic read_reg(input logic [`APB_ADDR_W-1:0] addr, output logic [31:0] data);
        @(posedge clk);
        #1;
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = 1'b0;
        apb_req.paddr   = addr;
        @(posedge clk);
        #1;
        apb_req.penable = 1'b1;
        @(negedge clk);
        check_value("pready", apb_rsp.pready, 1);
        data = apb_rsp.prdata;
        @(posedge clk);
        #1;
        apb_req = '0;
    endtask

    task automatic load_frame();
        logic err;
        for (int i = 0; i < NPIX; i++) begin
            lcg_state   = next_random(lcg_state);
            frame_px[i] = lcg_state[23:16];
            write_reg(`PIX_BASE + 12'(4 * i), {24'b0, frame_px[i]}, err);
            check_value("pslverr", err, 0);
        end
    endtask

    task automatic start_frame();
        logic err;
        write_reg(`REG_CTRL, 32'h1, err);
        check_value("pslverr", err, 0);
    endtask

    task automatic wait_frame_end(input int target);
        int cycles;
        cycles = 0;
        while (irq_count < target) begin
            @(posedge clk);
            cycles++;
            if (cycles > FRAME_CYCLES + 20) begin
                $display("frame_irq did not arrive within %0d cycles", cycles);
                $display("Finished with errors");
                $fatal(1, "frame timeout");
            end
        end
    endtask

    task automatic check_frame_result(input int frames);
        logic [31:0] rd;
        read_reg(`REG_STATUS, rd);
        check_value("STATUS", rd, 32'h2);  // frame_done set, busy clear
        read_reg(`REG_STATUS, rd);
        check_value("STATUS", rd, 32'h0);
        read_reg(`REG_COUNT, rd);
        check_value("COUNT", rd, WINS);
        check_value("frame_irq count", irq_count, frames);
        check_value("window count", win_seen, frames * WINS);
    endtask

    ////////////////////
    // Compare process

    always @(negedge clk) begin
        if (rst_n) begin
            if (frame_irq) irq_count++;
            if (win_valid) begin
                exp_win = expected_window(exp_row, exp_col);
                check_value("win.p00", win.p00, exp_win.p00);
                check_value("win.p01", win.p01, exp_win.p01);
                check_value("win.p02", win.p02, exp_win.p02);
                check_value("win.p10", win.p10, exp_win.p10);
                check_value("win.p11", win.p11, exp_win.p11);
                check_value("win.p12", win.p12, exp_win.p12);
                check_value("win.p20", win.p20, exp_win.p20);
                check_value("win.p21", win.p21, exp_win.p21);
                check_value("win.p22", win.p22, exp_win.p22);
                win_seen++;
                if (exp_col == `IMG_WIDTH - 1) begin
                    exp_col = `COL_THRESHOLD;  // Raster order wraps into the next frame
                    exp_row = (exp_row == `IMG_HEIGHT - 1) ? 0 : exp_row + 1;
                end else begin
                    exp_col++;
                end
            end
        end
    end

    initial begin
        #(WATCHDOG);
        $display("Run timed out after %0d time units", WATCHDOG);
        $display("Finished with errors");
        $fatal(1, "watchdog expired");
    end

    ////////////////////
    // Tests

    initial begin
        logic [31:0] rd;
        logic        err;
        apb_req = '0;
        rst_n   = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;
        read_reg(`REG_STATUS, rd);
        check_value("STATUS", rd, 32'h0);
        read_reg(`REG_COUNT, rd);
        check_value("COUNT", rd, 32'h0);

        load_frame();
        start_frame();
        wait_frame_end(1);
        check_frame_result(1);

        // The last pixel is still unread when this write lands, so it must be refused
        load_frame();
        start_frame();
        write_reg(`PIX_BASE + 12'(4 * (NPIX - 1)), {24'b0, ~frame_px[NPIX-1]}, err);
        check_value("pslverr", err, 1);
        wait_frame_end(2);
        check_frame_result(2);

        load_frame();
        start_frame();
        read_reg(`REG_STATUS, rd);
        check_value("STATUS", rd, 32'h1);
        wait_frame_end(3);
        check_frame_result(3);

        if (dut.u_chk.fail_count == 0) begin
            $display("Finished with no errors");
            $finish;
        end else begin
            $display("Assertion checks failed %0d times", dut.u_chk.fail_count);
            $display("Finished with errors");
            $fatal(1, "assertion failures");
        end
    end

endmodule

`default_nettype wire

// ==== window.f ====
+incdir+hdl
hdl/window_pkg.sv
hdl/apb_window_regs.sv
hdl/frame_store.sv
hdl/pixel_scan_counter.sv
hdl/window_controller.sv
hdl/line_buffer_window.sv
hdl/window_top.sv
testbench/window_chk.sv
testbench/window_tb.sv
